// File: cpu.f
+incdir+hw
+incdir+test
hw/cpu_pkg.sv
hw/cpu_ifs.sv
hw/fetch_unit.sv
hw/register_file.sv
hw/alu.sv
hw/decode_unit.sv
hw/execute_unit.sv
hw/memory_stage.sv
hw/cpu.sv
test/cpu_tb.sv

// File: hw/alu.sv
`include "cpu_config.svh"

module alu import cpu_pkg::*; (
  input  opcode_e              op,
  input  logic [`CPU_WORD-1:0] a,
  input  logic [`CPU_WORD-1:0] b,
  output logic [`CPU_WORD-1:0] result,
  output logic                 z,
  output logic                 v,
  output logic                 n
);
  localparam int W  = `CPU_WORD;
  localparam int SW = $clog2(W);

  logic [W-1:0]   sum;
  logic [W-1:0]   diff;
  logic [2*W-1:0] rot;
  logic [SW-1:0]  sh;

  // shift amount from low bits of b, 0..15
  assign sh   = b[SW-1:0];
  assign sum  = a + b;
  assign diff = a - b;
  // rotate right by shifting a doubled copy
  assign rot  = {a, a} >> sh;

  always_comb begin
    v = 1'b0;
    case (op)
      ADD: begin
        result = sum;
        // same-sign operands giving a different-sign sum
        v      = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
      end
      SUB: begin
        result = diff;
        v      = (a[W-1] != b[W-1]) && (diff[W-1] != a[W-1]);
      end
      XOR: result = a ^ b;
      SLL: result = a << sh;
      SRA: result = $signed(a) >>> sh;
      ROR: result = rot[W-1:0];
      // llb, lhb and the rest take b unchanged
      default: result = b;
    endcase
  end

  assign z = (result == '0);
  assign n = result[W-1];

endmodule

// File: hw/cpu.sv
`include "cpu_config.svh"

module cpu (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         run,
  input  logic                         imem_we,
  input  logic [`CPU_WORD-1:0]         imem_addr,
  input  logic [`CPU_WORD-1:0]         imem_wdata,
  output logic                         hlt,
  output logic [`CPU_WORD-1:0]         pc,
  output logic                         wb_en,
  output logic [$clog2(`CPU_REGS)-1:0] wb_reg,
  output logic [`CPU_WORD-1:0]         wb_data
);
  logic                 stall;
  logic                 halt_seen;
  logic                 br_taken;
  logic [`CPU_WORD-1:0] br_target;
  logic                 if_valid;
  logic [`CPU_WORD-1:0] if_instr;
  logic [`CPU_WORD-1:0] if_pc_plus2;

  // stage boundaries
  id_ex_if  id_ex ();
  ex_mem_if ex_mem ();

  fetch_unit u_fetch (
    .clk         (clk),
    .rst         (rst),
    .run         (run),
    .stall       (stall),
    .halt_seen   (halt_seen),
    .br_taken    (br_taken),
    .br_target   (br_target),
    .imem_we     (imem_we),
    .imem_addr   (imem_addr),
    .imem_wdata  (imem_wdata),
    .pc          (pc),
    .if_valid    (if_valid),
    .if_instr    (if_instr),
    .if_pc_plus2 (if_pc_plus2)
  );

  // write-back feeds the register file and the retire port together
  decode_unit u_decode (
    .clk         (clk),
    .rst         (rst),
    .if_valid    (if_valid),
    .if_instr    (if_instr),
    .if_pc_plus2 (if_pc_plus2),
    .br_taken    (br_taken),
    .wb_en       (wb_en),
    .wb_reg      (wb_reg),
    .wb_data     (wb_data),
    .stall       (stall),
    .halt_seen   (halt_seen),
    .id_ex       (id_ex.src),
    .ex_mem      (ex_mem.watch)
  );

  execute_unit u_execute (
    .clk       (clk),
    .rst       (rst),
    .br_taken  (br_taken),
    .br_target (br_target),
    .id_ex     (id_ex.dst),
    .ex_mem    (ex_mem.src)
  );

  memory_stage u_memory (
    .clk     (clk),
    .rst     (rst),
    .wb_en   (wb_en),
    .wb_reg  (wb_reg),
    .wb_data (wb_data),
    .hlt     (hlt),
    .ex_mem  (ex_mem.dst)
  );

endmodule

// File: hw/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data path and instruction width in bits
`define CPU_WORD 16

// architectural registers, r0 reads as zero
`define CPU_REGS 16

// program memory size in 16-bit words
`define IMEM_DEPTH 256

// data memory size in 16-bit words
`define DMEM_DEPTH 256

`endif

// File: hw/cpu_ifs.sv
`include "cpu_config.svh"

// decode to execute pipeline register contents
interface id_ex_if import cpu_pkg::*; ();
  logic                           valid;
  opcode_e                        op;
  logic [$clog2(`CPU_REGS)-1:0]   rd;
  logic [`CPU_WORD-1:0]           a_val;
  logic [`CPU_WORD-1:0]           b_val;
  logic [`CPU_WORD-1:0]           imm;
  logic [`CPU_WORD-1:0]           store_val;
  logic [`CPU_WORD-1:0]           pc_plus2;
  br_cond_e                       cond;
  // signed word offset of a branch
  logic [8:0]                     br_off;
  logic                           we_reg;

  modport src (output valid, op, rd, a_val, b_val, imm, store_val, pc_plus2, cond,
               br_off, we_reg);
  modport dst (input valid, op, rd, a_val, b_val, imm, store_val, pc_plus2, cond,
               br_off, we_reg);
endinterface

// execute to memory pipeline register contents
interface ex_mem_if ();
  logic                           valid;
  logic                           we_reg;
  logic [$clog2(`CPU_REGS)-1:0]   rd;
  // alu result, pcs value or byte address for lw/sw
  logic [`CPU_WORD-1:0]           result;
  logic                           mem_rd;
  logic                           mem_wr;
  logic [`CPU_WORD-1:0]           store_val;
  logic                           is_hlt;

  modport src (output valid, we_reg, rd, result, mem_rd, mem_wr, store_val, is_hlt);
  modport dst (input valid, we_reg, rd, result, mem_rd, mem_wr, store_val, is_hlt);
  // decode only needs the pending writer for its interlock
  modport watch (input valid, we_reg, rd);
endinterface

// File: hw/cpu_pkg.sv
package cpu_pkg;

  // instruction opcodes, bits 15:12 of every instruction
  typedef enum logic [3:0] {
    ADD  = 4'b0000,
    SUB  = 4'b0001,
    XOR  = 4'b0010,
    NOP0 = 4'b0011,
    SLL  = 4'b0100,
    SRA  = 4'b0101,
    ROR  = 4'b0110,
    NOP2 = 4'b0111,
    LW   = 4'b1000,
    SW   = 4'b1001,
    LLB  = 4'b1010,
    LHB  = 4'b1011,
    B    = 4'b1100,
    NOP1 = 4'b1101,
    PCS  = 4'b1110,
    HLT  = 4'b1111
  } opcode_e;

  // branch conditions, bits 11:9 of a B instruction
  typedef enum logic [2:0] {
    NE = 3'b000,
    EQ = 3'b001,
    GT = 3'b010,
    LT = 3'b011,
    GE = 3'b100,
    LE = 3'b101,
    OV = 3'b110,
    UN = 3'b111
  } br_cond_e;

  // zero, overflow and negative flags
  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } flags_t;

endpackage

// File: hw/decode_unit.sv
`include "cpu_config.svh"

module decode_unit import cpu_pkg::*; (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         if_valid,
  input  logic [`CPU_WORD-1:0]         if_instr,
  input  logic [`CPU_WORD-1:0]         if_pc_plus2,
  input  logic                         br_taken,
  input  logic                         wb_en,
  input  logic [$clog2(`CPU_REGS)-1:0] wb_reg,
  input  logic [`CPU_WORD-1:0]         wb_data,
  output logic                         stall,
  output logic                         halt_seen,
  id_ex_if.src                         id_ex,
  ex_mem_if.watch                      ex_mem
);
  localparam int RW = $clog2(`CPU_REGS);

  opcode_e              op;
  logic [RW-1:0]        rd;
  logic [RW-1:0]        rs;
  logic [RW-1:0]        rt;
  logic [RW-1:0]        ra;
  logic [RW-1:0]        rb;
  logic                 use_a;
  logic                 use_b;
  logic                 we_reg;
  logic                 wr_en;
  logic [`CPU_WORD-1:0] imm;
  logic [`CPU_WORD-1:0] mem_off;
  logic [`CPU_WORD-1:0] a_data;
  logic [`CPU_WORD-1:0] b_data;
  logic                 hazard_a;
  logic                 hazard_b;

  assign op = opcode_e'(if_instr[15:12]);
  assign rd = if_instr[11:8];
  assign rs = if_instr[7:4];
  assign rt = if_instr[3:0];

  // lw/sw offset, sign extended and scaled to bytes
  assign mem_off = {{(`CPU_WORD-5){if_instr[3]}}, if_instr[3:0], 1'b0};

  // read port selection, which ports matter, immediate form
  always_comb begin
    ra     = rs;
    rb     = rt;
    use_a  = 1'b0;
    use_b  = 1'b0;
    we_reg = 1'b0;
    imm    = '0;
    case (op)
      ADD, SUB, XOR: begin
        use_a  = 1'b1;
        use_b  = 1'b1;
        we_reg = 1'b1;
      end
      SLL, SRA, ROR: begin
        use_a  = 1'b1;
        we_reg = 1'b1;
        imm    = {{(`CPU_WORD-4){1'b0}}, rt};
      end
      LW: begin
        use_a  = 1'b1;
        we_reg = 1'b1;
        imm    = mem_off;
      end
      SW: begin
        // store data comes from rd on port b
        rb    = rd;
        use_a = 1'b1;
        use_b = 1'b1;
        imm   = mem_off;
      end
      LLB: begin
        we_reg = 1'b1;
        imm    = {{(`CPU_WORD-8){1'b0}}, if_instr[7:0]};
      end
      LHB: begin
        // old low byte of rd is kept
        ra     = rd;
        use_a  = 1'b1;
        we_reg = 1'b1;
        imm    = {{(`CPU_WORD-8){1'b0}}, if_instr[7:0]};
      end
      PCS: we_reg = 1'b1;
      default: ;
    endcase
  end

  // r0 writes are dropped here so they never stall or retire
  assign wr_en = we_reg && (rd != '0);

  register_file u_regs (
    .clk     (clk),
    .rst     (rst),
    .rs      (ra),
    .rt      (rb),
    .we      (wb_en),
    .wr_reg  (wb_reg),
    .wr_data (wb_data),
    .rs_data (a_data),
    .rt_data (b_data)
  );

  // interlock against writers still in execute or memory
  // write-back itself is covered by the register file bypass
  assign hazard_a = use_a && (ra != '0) &&
                    ((id_ex.valid && id_ex.we_reg && id_ex.rd == ra) ||
                     (ex_mem.valid && ex_mem.we_reg && ex_mem.rd == ra));
  assign hazard_b = use_b && (rb != '0) &&
                    ((id_ex.valid && id_ex.we_reg && id_ex.rd == rb) ||
                     (ex_mem.valid && ex_mem.we_reg && ex_mem.rd == rb));

  assign stall     = if_valid && (hazard_a || hazard_b);
  assign halt_seen = if_valid && (op == HLT);

  // ID/EX control, bubble on stall, flush or empty slot
  always_ff @(posedge clk) begin
    if (rst) begin
      id_ex.valid  <= 1'b0;
      id_ex.we_reg <= 1'b0;
    end else if (stall || br_taken || !if_valid) begin
      id_ex.valid  <= 1'b0;
      id_ex.we_reg <= 1'b0;
    end else begin
      id_ex.valid  <= 1'b1;
      id_ex.we_reg <= wr_en;
    end
  end

  // ID/EX payload
  always_ff @(posedge clk) begin
    id_ex.op        <= op;
    id_ex.rd        <= rd;
    id_ex.a_val     <= a_data;
    id_ex.b_val     <= b_data;
    id_ex.imm       <= imm;
    id_ex.store_val <= b_data;
    id_ex.pc_plus2  <= if_pc_plus2;
    id_ex.cond      <= br_cond_e'(if_instr[11:9]);
    id_ex.br_off    <= if_instr[8:0];
  end

endmodule

// File: hw/execute_unit.sv
`include "cpu_config.svh"

module execute_unit import cpu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  output logic                 br_taken,
  output logic [`CPU_WORD-1:0] br_target,
  id_ex_if.dst                 id_ex,
  ex_mem_if.src                ex_mem
);
  flags_t               flags;
  logic [`CPU_WORD-1:0] alu_b;
  logic [`CPU_WORD-1:0] alu_result;
  logic [`CPU_WORD-1:0] mem_addr;
  logic [`CPU_WORD-1:0] ex_result;
  logic                 alu_z;
  logic                 alu_v;
  logic                 alu_n;
  logic                 cond_met;

  // second alu operand, immediate for shifts/llb, merged byte for lhb
  always_comb begin
    case (id_ex.op)
      SLL, SRA, ROR, LLB: alu_b = id_ex.imm;
      LHB:                alu_b = {id_ex.imm[7:0], id_ex.a_val[7:0]};
      default:            alu_b = id_ex.b_val;
    endcase
  end

  alu u_alu (
    .op     (id_ex.op),
    .a      (id_ex.a_val),
    .b      (alu_b),
    .result (alu_result),
    .z      (alu_z),
    .v      (alu_v),
    .n      (alu_n)
  );

  // base plus scaled offset
  assign mem_addr = id_ex.a_val + id_ex.imm;

  always_comb begin
    case (id_ex.op)
      LW, SW:  ex_result = mem_addr;
      PCS:     ex_result = id_ex.pc_plus2;
      default: ex_result = alu_result;
    endcase
  end

  // flag register, z on all alu ops, v and n on add/sub only
  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (id_ex.valid) begin
      if (id_ex.op inside {ADD, SUB, XOR, SLL, SRA, ROR}) begin
        flags.z <= alu_z;
      end
      if (id_ex.op inside {ADD, SUB}) begin
        flags.v <= alu_v;
        flags.n <= alu_n;
      end
    end
  end

  always_comb begin
    case (id_ex.cond)
      NE:      cond_met = !flags.z;
      EQ:      cond_met = flags.z;
      GT:      cond_met = !flags.z && !flags.n;
      LT:      cond_met = flags.n;
      GE:      cond_met = flags.z || !flags.n;
      LE:      cond_met = flags.z || flags.n;
      OV:      cond_met = flags.v;
      default: cond_met = 1'b1;
    endcase
  end

  assign br_taken  = id_ex.valid && (id_ex.op == B) && cond_met;
  // pc + 2 + 2 * signed word offset
  assign br_target = id_ex.pc_plus2 +
                     {{(`CPU_WORD-10){id_ex.br_off[8]}}, id_ex.br_off, 1'b0};

  // EX/MEM control
  always_ff @(posedge clk) begin
    if (rst) begin
      ex_mem.valid  <= 1'b0;
      ex_mem.we_reg <= 1'b0;
      ex_mem.mem_rd <= 1'b0;
      ex_mem.mem_wr <= 1'b0;
      ex_mem.is_hlt <= 1'b0;
    end else begin
      ex_mem.valid  <= id_ex.valid;
      ex_mem.we_reg <= id_ex.valid && id_ex.we_reg;
      ex_mem.mem_rd <= id_ex.valid && (id_ex.op == LW);
      ex_mem.mem_wr <= id_ex.valid && (id_ex.op == SW);
      ex_mem.is_hlt <= id_ex.valid && (id_ex.op == HLT);
    end
  end

  // EX/MEM payload
  always_ff @(posedge clk) begin
    ex_mem.rd        <= id_ex.rd;
    ex_mem.result    <= ex_result;
    ex_mem.store_val <= id_ex.store_val;
  end

endmodule

// File: hw/fetch_unit.sv
`include "cpu_config.svh"

module fetch_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 run,
  input  logic                 stall,
  input  logic                 halt_seen,
  input  logic                 br_taken,
  input  logic [`CPU_WORD-1:0] br_target,
  input  logic                 imem_we,
  input  logic [`CPU_WORD-1:0] imem_addr,
  input  logic [`CPU_WORD-1:0] imem_wdata,
  output logic [`CPU_WORD-1:0] pc,
  output logic                 if_valid,
  output logic [`CPU_WORD-1:0] if_instr,
  output logic [`CPU_WORD-1:0] if_pc_plus2
);
  localparam int IA = $clog2(`IMEM_DEPTH);

  logic [`CPU_WORD-1:0] imem [`IMEM_DEPTH];
  logic [IA-1:0]        mem_addr;
  logic [`CPU_WORD-1:0] pc_plus2;
  logic                 advance;

  assign pc_plus2 = pc + `CPU_WORD'd2;
  // new fetch only when running, not interlocked and no hlt waiting in decode
  assign advance  = run && !stall && !halt_seen;
  // one address for load port and fetch, word index from byte address
  assign mem_addr = imem_we ? imem_addr[IA:1] : pc[IA:1];

  // program memory, registered read doubles as the IF/ID instruction
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[mem_addr] <= imem_wdata;
    end else if (advance) begin
      if_instr <= imem[mem_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      if_pc_plus2 <= pc_plus2;
    end
  end

  // pc and IF/ID valid
  always_ff @(posedge clk) begin
    if (rst) begin
      pc       <= '0;
      if_valid <= 1'b0;
    end else if (br_taken) begin
      // redirect, drop the instruction sitting in IF/ID
      pc       <= br_target;
      if_valid <= 1'b0;
    end else if (advance) begin
      pc       <= pc_plus2;
      if_valid <= 1'b1;
    end else if (!stall && !halt_seen) begin
      // run low, decode consumed the slot and nothing new arrives
      if_valid <= 1'b0;
    end
  end

endmodule

// File: hw/memory_stage.sv
`include "cpu_config.svh"

module memory_stage (
  input  logic                         clk,
  input  logic                         rst,
  output logic                         wb_en,
  output logic [$clog2(`CPU_REGS)-1:0] wb_reg,
  output logic [`CPU_WORD-1:0]         wb_data,
  output logic                         hlt,
  ex_mem_if.dst                        ex_mem
);
  localparam int DA = $clog2(`DMEM_DEPTH);

  logic [`CPU_WORD-1:0] dmem [`DMEM_DEPTH];
  logic [DA-1:0]        d_addr;
  logic [`CPU_WORD-1:0] ld_data;
  logic [`CPU_WORD-1:0] wb_result;
  logic                 wb_load;
  logic                 wb_hlt;

  // word index from the byte address
  assign d_addr = ex_mem.result[DA:1];

  // data memory, registered read lands with MEM/WB
  always_ff @(posedge clk) begin
    if (ex_mem.valid && ex_mem.mem_wr) begin
      dmem[d_addr] <= ex_mem.store_val;
    end
    ld_data <= dmem[d_addr];
  end

  // MEM/WB control and halt latch
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_en  <= 1'b0;
      wb_hlt <= 1'b0;
      hlt    <= 1'b0;
    end else begin
      wb_en  <= ex_mem.valid && ex_mem.we_reg;
      wb_hlt <= ex_mem.valid && ex_mem.is_hlt;
      // sticky until reset
      hlt    <= hlt || wb_hlt;
    end
  end

  always_ff @(posedge clk) begin
    wb_reg    <= ex_mem.rd;
    wb_result <= ex_mem.result;
    wb_load   <= ex_mem.mem_rd;
  end

  // write-back mux, load data or execute result
  assign wb_data = wb_load ? ld_data : wb_result;

endmodule

// File: hw/register_file.sv
`include "cpu_config.svh"

module register_file (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [$clog2(`CPU_REGS)-1:0] rs,
  input  logic [$clog2(`CPU_REGS)-1:0] rt,
  input  logic                         we,
  input  logic [$clog2(`CPU_REGS)-1:0] wr_reg,
  input  logic [`CPU_WORD-1:0]         wr_data,
  output logic [`CPU_WORD-1:0]         rs_data,
  output logic [`CPU_WORD-1:0]         rt_data
);
  logic [`CPU_WORD-1:0] regs [`CPU_REGS];

  // r0 hardwired, zero index reads zero and same-cycle write is bypassed
  function automatic logic [`CPU_WORD-1:0] read_port(
    input logic [$clog2(`CPU_REGS)-1:0] addr
  );
    if (addr == '0) begin
      return '0;
    end
    if (we && wr_reg == addr) begin
      return wr_data;
    end
    return regs[addr];
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `CPU_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wr_reg != '0) begin
      regs[wr_reg] <= wr_data;
    end
  end

  always_comb begin
    rs_data = read_port(rs);
    rt_data = read_port(rt);
  end

endmodule

// File: test/cpu_tb_model.svh
`ifndef CPU_TB_MODEL_SVH
`define CPU_TB_MODEL_SVH

// instruction-at-a-time interpreter for table entry t
// fills the expected write-back trace and the pc after HLT
task automatic model_program(input int t);
  logic [`CPU_WORD-1:0] r [`CPU_REGS];
  logic [`CPU_WORD-1:0] dmem_model [logic [`CPU_WORD-1:0]];
  logic [`CPU_WORD-1:0] pc;
  logic [`CPU_WORD-1:0] next_pc;
  logic [`CPU_WORD-1:0] w;
  logic [`CPU_WORD-1:0] a;
  logic [`CPU_WORD-1:0] res;
  logic [`CPU_WORD-1:0] addr;
  logic [3:0]           rd;
  logic [3:0]           sh;
  logic                 fz;
  logic                 fv;
  logic                 fn;
  logic                 wr;
  logic                 alu_op;
  logic                 take;
  int                   s;
  int                   steps;
  for (int i = 0; i < `CPU_REGS; i++) begin
    r[i] = '0;
  end
  pc = '0;
  fz = 1'b0;
  fv = 1'b0;
  fn = 1'b0;
  steps = 0;
  exp_cnt[t] = 0;
  forever begin
    assert (steps < 64 && pc < 32) else begin
      abort_run($sformatf("model for %s ran off the program without HLT", test_name[t]));
    end
    w = prog_tab[t][pc[4:1]];
    rd = w[11:8];
    sh = w[3:0];
    a = r[w[7:4]];
    // mem address, base plus twice the signed 4-bit offset
    addr = a + {{11{w[3]}}, w[3:0], 1'b0};
    next_pc = pc + 16'd2;
    wr = 1'b0;
    alu_op = 1'b0;
    res = '0;
    steps++;
    case (opcode_e'(w[15:12]))
      ADD, SUB: begin
        if (w[15:12] == 4'b0000) begin
          res = a + r[w[3:0]];
          s = int'($signed(a)) + int'($signed(r[w[3:0]]));
        end else begin
          res = a - r[w[3:0]];
          s = int'($signed(a)) - int'($signed(r[w[3:0]]));
        end
        // overflow when the exact sum leaves the 16-bit signed range
        fv = (s > 32767) || (s < -32768);
        fn = res[15];
        wr = 1'b1;
        alu_op = 1'b1;
      end
      XOR, SLL, SRA, ROR: begin
        case (w[15:12])
          4'b0010: res = a ^ r[w[3:0]];
          4'b0100: res = a << sh;
          // fill vacated high bits with copies of the sign
          4'b0101: res = (a >> sh) | (a[15] ? ~(16'hffff >> sh) : 16'h0000);
          default: res = (a >> sh) | (a << (16 - sh));
        endcase
        wr = 1'b1;
        alu_op = 1'b1;
      end
      LW: begin
        assert (dmem_model.exists(addr)) else begin
          abort_run($sformatf("%s loads address %h that was never stored", test_name[t], addr));
        end
        res = dmem_model[addr];
        wr = 1'b1;
      end
      SW: dmem_model[addr] = r[rd];
      LLB: begin
        res = {8'h00, w[7:0]};
        wr = 1'b1;
      end
      LHB: begin
        res = {w[7:0], r[rd][7:0]};
        wr = 1'b1;
      end
      B: begin
        case (br_cond_e'(w[11:9]))
          NE:      take = !fz;
          EQ:      take = fz;
          GT:      take = !fz && !fn;
          LT:      take = fn;
          GE:      take = fz || !fn;
          LE:      take = fz || fn;
          OV:      take = fv;
          default: take = 1'b1;
        endcase
        if (take) begin
          next_pc = pc + 16'd2 + {{6{w[8]}}, w[8:0], 1'b0};
        end
      end
      PCS: begin
        res = pc + 16'd2;
        wr = 1'b1;
      end
      HLT: begin
        exp_pc[t] = pc + 16'd2;
        return;
      end
      default: ;
    endcase
    if (alu_op) begin
      fz = (res == '0);
    end
    // r0 stays zero and never shows up on the retire port
    if (wr && rd != 4'd0) begin
      r[rd] = res;
      exp_reg[t][exp_cnt[t]] = rd;
      exp_data[t][exp_cnt[t]] = res;
      exp_cnt[t]++;
    end
    pc = next_pc;
  end
endtask

`endif

// File: test/cpu_tb.sv
`include "cpu_config.svh"

module cpu_tb import cpu_pkg::*; ();
  localparam int NDIR        = 6;
  localparam int NRAND       = 4;
  localparam int NTESTS      = NDIR + NRAND;
  localparam int MAXB        = 64;
  // each test allows for the load, up to 7 cycles per program word, reset and drain
  localparam int CYCLE_LIMIT = NTESTS * (16 + 16 * 7 + 20);

  logic                         clk;
  logic                         rst;
  logic                         run;
  logic                         imem_we;
  logic [`CPU_WORD-1:0]         imem_addr;
  logic [`CPU_WORD-1:0]         imem_wdata;
  logic                         hlt;
  logic [`CPU_WORD-1:0]         pc;
  logic                         wb_en;
  logic [$clog2(`CPU_REGS)-1:0] wb_reg;
  logic [`CPU_WORD-1:0]         wb_data;

  // program table and the expected trace the model derives from it
  string                test_name [NTESTS];
  logic [`CPU_WORD-1:0] prog_tab  [NTESTS][16];
  logic [3:0]           exp_reg   [NTESTS][MAXB];
  logic [`CPU_WORD-1:0] exp_data  [NTESTS][MAXB];
  int                   exp_cnt   [NTESTS];
  logic [`CPU_WORD-1:0] exp_pc    [NTESTS];
  int                   fill_idx;
  int                   cycles;

  cpu UUT (
    .clk        (clk),
    .rst        (rst),
    .run        (run),
    .imem_we    (imem_we),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .hlt        (hlt),
    .pc         (pc),
    .wb_en      (wb_en),
    .wb_reg     (wb_reg),
    .wb_data    (wb_data)
  );

  always #20 clk = ~clk;

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  `include "cpu_tb_model.svh"

  always @(posedge clk) begin
    cycles++;
    assert (cycles <= CYCLE_LIMIT) else begin
      abort_run($sformatf("timeout, no halt within %0d cycles", CYCLE_LIMIT));
    end
  end

  // instruction encoders
  function automatic logic [15:0] r_word(opcode_e op, logic [3:0] rd, logic [3:0] rs,
                                         logic [3:0] rt);
    return {op, rd, rs, rt};
  endfunction

  function automatic logic [15:0] i_word(opcode_e op, logic [3:0] rd, logic [7:0] imm);
    return {op, rd, imm};
  endfunction

  function automatic logic [15:0] b_word(br_cond_e cond, logic [8:0] off);
    return {B, cond, off};
  endfunction

  // unused words stay HLT so nothing past the program is undefined
  task automatic start_program(input int t, input string name);
    test_name[t] = name;
    fill_idx = 0;
    for (int i = 0; i < 16; i++) begin
      prog_tab[t][i] = {HLT, 12'h000};
    end
  endtask

  task automatic add_word(input int t, input logic [15:0] w);
    prog_tab[t][fill_idx] = w;
    fill_idx++;
  endtask

  task automatic build_directed();
    start_program(0, "alu_ops");
    add_word(0, i_word(LLB, 1, 8'h34));
    add_word(0, i_word(LHB, 1, 8'h12));
    add_word(0, i_word(LLB, 2, 8'hff));
    add_word(0, i_word(LHB, 2, 8'h7f));
    // 0x7fff + 0x1234 wraps negative
    add_word(0, r_word(ADD, 3, 2, 1));
    add_word(0, r_word(SUB, 4, 1, 2));
    add_word(0, r_word(XOR, 5, 1, 2));
    add_word(0, r_word(SLL, 6, 1, 4));
    add_word(0, r_word(SRA, 7, 4, 3));
    add_word(0, r_word(ROR, 8, 1, 5));
    add_word(0, r_word(ADD, 0, 1, 2));
    add_word(0, r_word(SUB, 9, 0, 1));
    start_program(1, "half_pcs");
    add_word(1, i_word(LLB, 1, 8'ha5));
    add_word(1, i_word(LHB, 1, 8'h5a));
    add_word(1, r_word(PCS, 2, 0, 0));
    add_word(1, i_word(LLB, 3, 8'h80));
    add_word(1, i_word(LHB, 3, 8'hc3));
    add_word(1, r_word(PCS, 0, 0, 0));
    add_word(1, r_word(ADD, 4, 2, 3));
    start_program(2, "store_load");
    add_word(2, i_word(LLB, 1, 8'h40));
    add_word(2, i_word(LLB, 2, 8'h11));
    add_word(2, i_word(LHB, 2, 8'hbe));
    add_word(2, r_word(SW, 2, 1, 4'he));
    add_word(2, r_word(SW, 1, 1, 4'h7));
    add_word(2, r_word(LW, 3, 1, 4'he));
    add_word(2, r_word(ADD, 4, 3, 3));
    add_word(2, r_word(LW, 5, 1, 4'h7));
    add_word(2, r_word(SUB, 6, 5, 3));
    add_word(2, r_word(SW, 6, 1, 4'h0));
    add_word(2, r_word(LW, 7, 1, 4'h0));
    add_word(2, r_word(XOR, 8, 7, 2));
    start_program(3, "branch_conds");
    add_word(3, i_word(LLB, 1, 8'h01));
    add_word(3, i_word(LLB, 2, 8'h02));
    add_word(3, r_word(SUB, 3, 1, 2));
    add_word(3, b_word(LT, 9'd2));
    add_word(3, i_word(LLB, 4, 8'haa));
    add_word(3, i_word(LLB, 5, 8'hbb));
    add_word(3, b_word(EQ, 9'd1));
    add_word(3, i_word(LLB, 6, 8'h11));
    // xor sets z and leaves n from the sub
    add_word(3, r_word(XOR, 7, 1, 1));
    add_word(3, b_word(GE, 9'd1));
    add_word(3, i_word(LLB, 8, 8'h22));
    add_word(3, b_word(NE, 9'd1));
    add_word(3, i_word(LLB, 9, 8'h33));
    add_word(3, b_word(UN, 9'd1));
    add_word(3, i_word(LLB, 10, 8'h44));
    start_program(4, "branch_loop");
    add_word(4, i_word(LLB, 1, 8'hff));
    add_word(4, i_word(LHB, 1, 8'h7f));
    add_word(4, i_word(LLB, 2, 8'h01));
    add_word(4, r_word(ADD, 3, 1, 2));
    add_word(4, b_word(OV, 9'd1));
    add_word(4, i_word(LLB, 4, 8'h99));
    add_word(4, b_word(GT, 9'd1));
    add_word(4, i_word(LLB, 6, 8'h03));
    // count r6 down to zero with a backward branch
    add_word(4, r_word(SUB, 6, 6, 2));
    add_word(4, b_word(NE, 9'h1fe));
    add_word(4, b_word(GT, 9'd1));
    add_word(4, r_word(SLL, 7, 2, 15));
    // a wrongly taken le lands on the ror
    add_word(4, b_word(LE, 9'd1));
    // gt taken skips the ror and goes to the trailing hlt
    add_word(4, b_word(GT, 9'd1));
    add_word(4, r_word(ROR, 8, 7, 15));
    start_program(5, "halt_stop");
    add_word(5, i_word(LLB, 1, 8'h05));
    add_word(5, r_word(ADD, 2, 1, 1));
    add_word(5, {HLT, 12'h000});
    add_word(5, i_word(LLB, 3, 8'h77));
    add_word(5, i_word(LLB, 4, 8'h88));
  endtask

  // straight-line program where r1 is a fixed base so each lw reads a word stored earlier
  task automatic random_program(input int t);
    opcode_e    alu_ops [6] = '{ADD, SUB, XOR, SLL, SRA, ROR};
    int         k;
    int         kind;
    logic [3:0] dst;
    logic [3:0] off;
    start_program(t, $sformatf("random_%0d", t - NDIR));
    add_word(t, i_word(LLB, 1, 8'h40 + 8'($urandom_range(31, 0) * 2)));
    k = 1;
    while (k < 15) begin
      kind = $urandom_range(3, 0);
      dst = 4'($urandom_range(15, 0));
      if (dst == 4'd1) begin
        dst = 4'd0;
      end
      if (kind < 2) begin
        add_word(t, r_word(alu_ops[$urandom_range(5, 0)], dst, 4'($urandom), 4'($urandom)));
        k++;
      end else if (kind == 3 && k < 14) begin
        off = 4'($urandom);
        add_word(t, r_word(SW, 4'($urandom), 1, off));
        add_word(t, r_word(LW, dst, 1, off));
        k += 2;
      end else begin
        add_word(t, i_word(LLB, dst, 8'($urandom)));
        k++;
      end
    end
  endtask

  task automatic run_test(input int t);
    int beat;
    @(posedge clk);
    #2;
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    for (int i = 0; i < 16; i++) begin
      imem_we    = 1'b1;
      imem_addr  = 16'(2 * i);
      imem_wdata = prog_tab[t][i];
      @(posedge clk);
      #2;
    end
    imem_we = 1'b0;
    run     = 1'b1;
    beat    = 0;
    // retire port sampled mid-cycle
    while (!hlt) begin
      @(negedge clk);
      if (wb_en) begin
        assert (beat < exp_cnt[t]) else begin
          abort_run($sformatf("%s retired more than the %0d expected write-backs",
                              test_name[t], exp_cnt[t]));
        end
        assert (wb_reg === exp_reg[t][beat] && wb_data === exp_data[t][beat]) else begin
          abort_run($sformatf("ERR %s beat %0d: expected r%0d=%h, actual r%0d=%h",
                              test_name[t], beat, exp_reg[t][beat], exp_data[t][beat],
                              wb_reg, wb_data));
        end
        beat++;
      end
    end
    assert (beat == exp_cnt[t]) else begin
      abort_run($sformatf("%s halted after %0d of %0d expected write-backs",
                          test_name[t], beat, exp_cnt[t]));
    end
    assert (pc === exp_pc[t]) else begin
      abort_run($sformatf("ERR %s final pc: expected %h, actual %h",
                          test_name[t], exp_pc[t], pc));
    end
    // nothing behind the HLT may retire, and hlt holds
    repeat (4) begin
      @(negedge clk);
      assert (!wb_en) else begin
        abort_run($sformatf("%s retired an instruction after halting", test_name[t]));
      end
      assert (hlt) else begin
        abort_run($sformatf("%s dropped hlt before reset", test_name[t]));
      end
    end
    @(posedge clk);
    #2;
    run = 1'b0;
  endtask

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    run        = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    cycles     = 0;
    void'($urandom(32'hf573_ae18));
    build_directed();
    for (int t = NDIR; t < NTESTS; t++) begin
      random_program(t);
    end
    for (int t = 0; t < NTESTS; t++) begin
      model_program(t);
    end
    for (int t = 0; t < NTESTS; t++) begin
      run_test(t);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule
